//--- hw/dmaRegPkg.sv
package dmaRegPkg;

  // Register port and programming model widths
  typedef logic [7:0] dataT;
  typedef logic [15:0] addrT;
  typedef logic [15:0] countT;
  typedef logic [3:0] regSelT;
  typedef logic [1:0] channelT;
  typedef logic [1:0] xferTypeT;

  localparam int numChannels = 4;

  // Selects 0 to 7 are the address and count words, two per channel
  localparam regSelT regModeSel = 4'd11;
  localparam regSelT regClearFlipFlopSel = 4'd12;
  localparam regSelT regMaskSel = 4'd15;

  // Transfer types; 00 and 11 are verify
  localparam xferTypeT xferWrite = 2'b01;
  localparam xferTypeT xferRead = 2'b10;

endpackage

//--- hw/dmaBusPkg.sv
package dmaBusPkg;

  // One bit per channel for dreq, dack and mask
  typedef logic [3:0] reqT;

  // Bit positions of the one-hot state vector
  localparam int idleIdx = 0;
  localparam int holdIdx = 1;
  localparam int s1Idx = 2;
  localparam int s2Idx = 3;
  localparam int s4Idx = 4;

  typedef enum logic [4:0] {
    idle = 5'b00001 << idleIdx,
    hold = 5'b00001 << holdIdx,
    s1 = 5'b00001 << s1Idx,
    s2 = 5'b00001 << s2Idx,
    s4 = 5'b00001 << s4Idx
  } stateT;

endpackage

//--- hw/priorityLogic.sv
`timescale 1ns/1ps

module priorityLogic (
  input  logic CLK,
  input  logic rstN,
  input  dmaBusPkg::reqT dreq,
  input  dmaBusPkg::reqT mask,
  input  logic grantLatch,
  input  logic dackEnable,
  output logic anyReq,
  output dmaRegPkg::channelT activeChannel,
  output dmaBusPkg::reqT dack
);

  dmaBusPkg::reqT pending;
  dmaRegPkg::channelT winner;

  assign pending = dreq & ~mask;
  assign anyReq = |pending;

  // Fixed priority, channel 0 highest
  always_comb
  begin
    if (pending[0])
      winner = 2'd0;
    else if (pending[1])
      winner = 2'd1;
    else if (pending[2])
      winner = 2'd2;
    else
      winner = 2'd3;
  end

  // Held for the whole transfer even if dreq drops
  always_ff @(posedge CLK)
  begin
    if (!rstN)
      activeChannel <= 2'd0;
    else if (grantLatch)
      activeChannel <= winner;
  end

  always_comb
  begin
    dack = '0;
    if (dackEnable)
      dack[activeChannel] = 1'b1;
  end

endmodule

//--- hw/dmaRegisters.sv
`timescale 1ns/1ps

module dmaRegisters (
  input  logic CLK,
  input  logic rstN,
  input  logic cpuWr,
  input  dmaRegPkg::regSelT cpuSel,
  input  dmaRegPkg::dataT cpuData,
  input  logic progEnable,
  input  dmaRegPkg::channelT activeChannel,
  input  logic updateCount,
  output dmaBusPkg::reqT mask,
  output dmaRegPkg::xferTypeT xferType,
  output dmaRegPkg::addrT curAddr,
  output logic countZero
);

  dmaRegPkg::addrT baseAddr [dmaRegPkg::numChannels];
  dmaRegPkg::addrT curAddrReg [dmaRegPkg::numChannels];
  dmaRegPkg::countT baseCount [dmaRegPkg::numChannels];
  dmaRegPkg::countT curCount [dmaRegPkg::numChannels];
  dmaRegPkg::xferTypeT mode [dmaRegPkg::numChannels];
  logic highByte;
  logic wrEn;
  logic addrWr;
  logic countWr;
  dmaRegPkg::channelT selChannel;
  dmaRegPkg::channelT modeChannel;

  assign wrEn = cpuWr && progEnable;
  assign addrWr = wrEn && !cpuSel[3] && !cpuSel[0];
  assign countWr = wrEn && !cpuSel[3] && cpuSel[0];
  assign selChannel = cpuSel[2:1];
  assign modeChannel = cpuData[1:0];

  // High byte write completes the current copy from the stored low byte
  always_ff @(posedge CLK)
  begin
    if (addrWr && highByte)
    begin
      baseAddr[selChannel][15:8] <= cpuData;
      curAddrReg[selChannel] <= {cpuData, baseAddr[selChannel][7:0]};
    end
    else if (addrWr)
    begin
      baseAddr[selChannel][7:0] <= cpuData;
      curAddrReg[selChannel][7:0] <= cpuData;
    end
    else if (updateCount)
      curAddrReg[activeChannel] <= curAddrReg[activeChannel] + 16'd1;
  end

  // Count wraps below zero, so N programs N+1 transfers
  always_ff @(posedge CLK)
  begin
    if (countWr && highByte)
    begin
      baseCount[selChannel][15:8] <= cpuData;
      curCount[selChannel] <= {cpuData, baseCount[selChannel][7:0]};
    end
    else if (countWr)
    begin
      baseCount[selChannel][7:0] <= cpuData;
      curCount[selChannel][7:0] <= cpuData;
    end
    else if (updateCount)
      curCount[activeChannel] <= curCount[activeChannel] - 16'd1;
  end

  always_ff @(posedge CLK)
  begin
    if (wrEn && cpuSel == dmaRegPkg::regModeSel)
      mode[modeChannel] <= cpuData[3:2];
  end

  always_ff @(posedge CLK)
  begin
    if (!rstN)
    begin
      mask <= '1;
      highByte <= 1'b0;
    end
    else
    begin
      if (addrWr || countWr)
        highByte <= !highByte;
      else if (wrEn && cpuSel == dmaRegPkg::regClearFlipFlopSel)
        highByte <= 1'b0;
      if (wrEn && cpuSel == dmaRegPkg::regMaskSel)
        mask <= cpuData[3:0];
      else if (updateCount && countZero)
        mask[activeChannel] <= 1'b1;   // terminal count
    end
  end

  assign xferType = mode[activeChannel];
  assign curAddr = curAddrReg[activeChannel];
  assign countZero = curCount[activeChannel] == '0;

endmodule

//--- hw/timingControl.sv
`timescale 1ns/1ps

module timingControl (
  input  logic CLK,
  input  logic rstN,
  input  logic anyReq,
  input  logic hlda,
  input  logic cpuWr,
  input  dmaRegPkg::xferTypeT xferType,
  input  logic countZero,
  output logic hrq,
  output logic aen,
  output logic adstb,
  output logic memrN,
  output logic memwN,
  output logic iorN,
  output logic iowN,
  output logic eopN,
  output logic grantLatch,
  output logic dackEnable,
  output logic updateCount,
  output logic progEnable
);

  dmaBusPkg::stateT state;
  dmaBusPkg::stateT nextState;

  always_ff @(posedge CLK)
  begin
    if (!rstN)
      state <= dmaBusPkg::idle;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    unique case (1'b1)
      state[dmaBusPkg::idleIdx]:
        if (anyReq)
          nextState = dmaBusPkg::hold;
      state[dmaBusPkg::holdIdx]:
        if (hlda)
          nextState = dmaBusPkg::s1;
      state[dmaBusPkg::s1Idx]:
        nextState = dmaBusPkg::s2;
      state[dmaBusPkg::s2Idx]:
        nextState = dmaBusPkg::s4;
      default:
        nextState = dmaBusPkg::idle;
    endcase
  end

  // Outputs decoded from the state
  always_comb
  begin
    hrq = 1'b0;
    aen = 1'b0;
    adstb = 1'b0;
    memrN = 1'b1;
    memwN = 1'b1;
    iorN = 1'b1;
    iowN = 1'b1;
    eopN = 1'b1;
    grantLatch = 1'b0;
    dackEnable = 1'b0;
    updateCount = 1'b0;
    progEnable = 1'b0;
    unique case (1'b1)
      state[dmaBusPkg::idleIdx]:
      begin
        grantLatch = anyReq;
        // Host owns the bus only while hlda is low
        progEnable = cpuWr && !hlda;
      end
      state[dmaBusPkg::holdIdx]:
        hrq = 1'b1;
      state[dmaBusPkg::s1Idx]:
      begin
        hrq = 1'b1;
        aen = 1'b1;
        adstb = 1'b1;
        dackEnable = 1'b1;
      end
      state[dmaBusPkg::s2Idx]:
      begin
        hrq = 1'b1;
        aen = 1'b1;
        dackEnable = 1'b1;
        if (xferType == dmaRegPkg::xferWrite)
        begin
          iorN = 1'b0;
          memwN = 1'b0;
        end
        else if (xferType == dmaRegPkg::xferRead)
        begin
          memrN = 1'b0;
          iowN = 1'b0;
        end
      end
      default:
      begin
        // S4 leaves the strobes released
        hrq = 1'b1;
        aen = 1'b1;
        dackEnable = 1'b1;
        updateCount = 1'b1;
        eopN = !countZero;
      end
    endcase
  end

endmodule

//--- hw/dma.sv
`timescale 1ns/1ps

module dma (
  input  logic CLK,
  input  logic rstN,
  input  logic cpuWr,
  input  dmaRegPkg::regSelT cpuSel,
  input  dmaRegPkg::dataT cpuData,
  input  dmaBusPkg::reqT dreq,
  input  logic hlda,
  output logic hrq,
  output logic aen,
  output logic adstb,
  output dmaRegPkg::addrT addrOut,
  output dmaBusPkg::reqT dack,
  output logic memrN,
  output logic memwN,
  output logic iorN,
  output logic iowN,
  output logic eopN
);

  logic anyReq;
  logic grantLatch;
  logic dackEnable;
  logic updateCount;
  logic progEnable;
  logic countZero;
  dmaBusPkg::reqT mask;
  dmaRegPkg::channelT activeChannel;
  dmaRegPkg::xferTypeT xferType;

  priorityLogic priorityLogic_i (
    .CLK           (CLK),
    .rstN          (rstN),
    .dreq          (dreq),
    .mask          (mask),
    .grantLatch    (grantLatch),
    .dackEnable    (dackEnable),
    .anyReq        (anyReq),
    .activeChannel (activeChannel),
    .dack          (dack)
  );

  dmaRegisters dmaRegisters_i (
    .CLK           (CLK),
    .rstN          (rstN),
    .cpuWr         (cpuWr),
    .cpuSel        (cpuSel),
    .cpuData       (cpuData),
    .progEnable    (progEnable),
    .activeChannel (activeChannel),
    .updateCount   (updateCount),
    .mask          (mask),
    .xferType      (xferType),
    .curAddr       (addrOut),
    .countZero     (countZero)
  );

  timingControl timingControl_i (
    .CLK         (CLK),
    .rstN        (rstN),
    .anyReq      (anyReq),
    .hlda        (hlda),
    .cpuWr       (cpuWr),
    .xferType    (xferType),
    .countZero   (countZero),
    .hrq         (hrq),
    .aen         (aen),
    .adstb       (adstb),
    .memrN       (memrN),
    .memwN       (memwN),
    .iorN        (iorN),
    .iowN        (iowN),
    .eopN        (eopN),
    .grantLatch  (grantLatch),
    .dackEnable  (dackEnable),
    .updateCount (updateCount),
    .progEnable  (progEnable)
  );

endmodule

//--- testbench/dma_properties.sv
`timescale 1ns/1ps

module dma_properties (
  input  logic CLK,
  input  logic rstN,
  input  logic hlda,
  input  logic aen,
  input  logic memrN,
  input  logic memwN,
  input  logic iorN,
  input  logic iowN,
  input  dmaBusPkg::reqT dack,
  input  dmaBusPkg::stateT state
);

  logic strobeActive;

  assign strobeActive = !memrN || !memwN || !iorN || !iowN;

  aenNeedsHlda: assert property (@(posedge CLK) disable iff (!rstN) aen |-> hlda)
    else $error("aen high while hlda is low");

  strobesOnlyInS2: assert property (@(posedge CLK) disable iff (!rstN)
    strobeActive |-> state == dmaBusPkg::s2)
    else $error("Strobe active outside s2");

  // A single dack, present exactly while the address is enabled
  dackOneHot: assert property (@(posedge CLK) disable iff (!rstN)
    $onehot0(dack) && ((dack != '0) == aen))
    else $error("dack not one-hot or not in step with aen");

  // One cycle each for s1, s2 and s4 once the bus is granted
  grantRunsCycle: assert property (@(posedge CLK) disable iff (!rstN)
    (state == dmaBusPkg::hold && hlda) |=>
      state == dmaBusPkg::s1 ##1 state == dmaBusPkg::s2 ##1 state == dmaBusPkg::s4)
    else $error("Transfer cycle did not follow hlda");

endmodule

bind dma dma_properties dma_properties_i (
  .CLK   (CLK),
  .rstN  (rstN),
  .hlda  (hlda),
  .aen   (aen),
  .memrN (memrN),
  .memwN (memwN),
  .iorN  (iorN),
  .iowN  (iowN),
  .dack  (dack),
  .state (timingControl_i.state)
);

//--- testbench/dmaTb.sv
`timescale 1ns/1ps

module dmaTb;

  localparam int plannedTransfers = 10;
  localparam int cyclesPerTransfer = 40;

  logic CLK;
  logic rstN;
  logic cpuWr;
  dmaRegPkg::regSelT cpuSel;
  dmaRegPkg::dataT cpuData;
  dmaBusPkg::reqT dreq;
  logic hlda;
  logic hrq;
  logic aen;
  logic adstb;
  dmaRegPkg::addrT addrOut;
  dmaBusPkg::reqT dack;
  logic memrN;
  logic memwN;
  logic iorN;
  logic iowN;
  logic eopN;

  // Model of the programming state
  dmaRegPkg::addrT refAddr [dmaRegPkg::numChannels];
  dmaRegPkg::countT refCount [dmaRegPkg::numChannels];
  dmaRegPkg::xferTypeT refType [dmaRegPkg::numChannels];
  dmaBusPkg::reqT refMask;
  logic refHighByte;

  integer seed = 68549;
  int transfers = 0;
  string testName = "reset";

  dma dut_i (.*);

  initial
  begin
    CLK = 1'b0;
    forever
      #50 CLK = !CLK;
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic checkAddr(input dmaRegPkg::addrT expected, input dmaRegPkg::addrT actual);
    if (actual !== expected)
      abortRun($sformatf("Error %s: address expected %h, actual %h",
        testName, expected, actual));
  endtask

  task automatic checkDack(input dmaBusPkg::reqT expected, input dmaBusPkg::reqT actual);
    if (actual !== expected)
      abortRun($sformatf("Error %s: dack expected %b, actual %b",
        testName, expected, actual));
  endtask

  task automatic checkStrobes(input logic [3:0] expected, input logic [3:0] actual);
    if (actual !== expected)
      abortRun($sformatf("Error %s: strobes expected %b, actual %b",
        testName, expected, actual));
  endtask

  task automatic checkEop(input logic expected, input logic actual);
    if (actual !== expected)
      abortRun($sformatf("Error %s: eopN expected %b, actual %b",
        testName, expected, actual));
  endtask

  // Bit order aen, adstb
  task automatic checkBusControl(input logic [1:0] expected, input logic [1:0] actual);
    if (actual !== expected)
      abortRun($sformatf("Error %s: aen and adstb expected %b, actual %b",
        testName, expected, actual));
  endtask

  // Lowest unmasked channel wins; strobes in order memrN, memwN, iorN, iowN
  function automatic void expectTransfer(
    input  dmaBusPkg::reqT req,
    output dmaRegPkg::channelT ch,
    output dmaRegPkg::addrT addr,
    output logic [3:0] strobes,
    output logic terminal
  );
    dmaBusPkg::reqT pending;
    int i;
    pending = req & ~refMask;
    ch = 2'd3;
    for (i = dmaRegPkg::numChannels - 1; i >= 0; i--)
      if (pending[i])
        ch = i[1:0];
    addr = refAddr[ch];
    case (refType[ch])
      2'b01: strobes = 4'b1001;
      2'b10: strobes = 4'b0110;
      default: strobes = 4'b1111;
    endcase
    terminal = refCount[ch] == '0;
  endfunction

  function automatic void applyWrite(input dmaRegPkg::regSelT sel, input dmaRegPkg::dataT data);
    dmaRegPkg::channelT ch;
    ch = sel[2:1];
    if (!sel[3] && !sel[0])
    begin
      if (refHighByte)
        refAddr[ch][15:8] = data;
      else
        refAddr[ch][7:0] = data;
      refHighByte = !refHighByte;
    end
    else if (!sel[3])
    begin
      if (refHighByte)
        refCount[ch][15:8] = data;
      else
        refCount[ch][7:0] = data;
      refHighByte = !refHighByte;
    end
    else if (sel == dmaRegPkg::regModeSel)
      refType[data[1:0]] = data[3:2];
    else if (sel == dmaRegPkg::regClearFlipFlopSel)
      refHighByte = 1'b0;
    else if (sel == dmaRegPkg::regMaskSel)
      refMask = data[3:0];
  endfunction

  task automatic writeReg(input dmaRegPkg::regSelT sel, input dmaRegPkg::dataT data);
    logic accepted;
    @(posedge CLK);
    #1 cpuWr = 1'b1;
    cpuSel = sel;
    cpuData = data;
    @(negedge CLK);
    // Host owns the registers only in idle with the bus released
    accepted = !hrq && !hlda;
    @(posedge CLK);
    #1 cpuWr = 1'b0;
    if (accepted)
      applyWrite(sel, data);
  endtask

  task automatic programChannel(input dmaRegPkg::channelT ch, input dmaRegPkg::addrT addr,
    input dmaRegPkg::countT count, input dmaRegPkg::xferTypeT xferType);
    writeReg(dmaRegPkg::regClearFlipFlopSel, 8'h00);
    writeReg({1'b0, ch, 1'b0}, addr[7:0]);
    writeReg({1'b0, ch, 1'b0}, addr[15:8]);
    writeReg({1'b0, ch, 1'b1}, count[7:0]);
    writeReg({1'b0, ch, 1'b1}, count[15:8]);
    writeReg(dmaRegPkg::regModeSel, {4'b0000, xferType, ch});
  endtask

  task automatic unmaskChannel(input dmaRegPkg::channelT ch);
    writeReg(dmaRegPkg::regMaskSel, {4'b0000, refMask & ~(4'b0001 << ch)});
  endtask

  task automatic raiseReq(input dmaBusPkg::reqT bits);
    @(posedge CLK);
    #1 dreq = dreq | bits;
  endtask

  // Peripheral drops its request once acknowledged, then the bus is handed back
  task automatic finishReq(input dmaRegPkg::channelT ch);
    @(negedge CLK);
    while (!dack[ch])
      @(negedge CLK);
    @(posedge CLK);
    #1 dreq[ch] = 1'b0;
    @(negedge CLK);
    while (aen || hlda)
      @(negedge CLK);
  endtask

  task automatic serveChannel(input dmaRegPkg::channelT ch);
    raiseReq(4'b0001 << ch);
    finishReq(ch);
  endtask

  task automatic expectNoRequest(input int cycles);
    repeat (cycles)
    begin
      @(negedge CLK);
      if (hrq)
        abortRun($sformatf("%s: hrq was raised for a masked request", testName));
    end
  endtask

  initial
  begin : hldaResponder
    int delay;
    hlda = 1'b0;
    forever
    begin
      @(negedge CLK);
      if (hrq && !hlda)
      begin
        delay = 1 + int'($unsigned($random(seed)) % 4);
        repeat (delay)
          @(posedge CLK);
        #1 hlda = 1'b1;
        while (!aen)
          @(negedge CLK);
        while (aen)
          @(negedge CLK);
        @(posedge CLK);
        #1 hlda = 1'b0;
      end
    end
  end

  initial
  begin : transferMonitor
    dmaBusPkg::reqT grantReq;
    dmaRegPkg::channelT ch;
    dmaRegPkg::addrT addr;
    logic [3:0] strobes;
    logic terminal;
    grantReq = '0;
    forever
    begin
      @(negedge CLK);
      // Requests as seen by the idle to hold edge
      if (!hrq)
        grantReq = dreq;
      if (adstb)
      begin
        expectTransfer(grantReq, ch, addr, strobes, terminal);
        checkAddr(addr, addrOut);
        checkBusControl(2'b11, {aen, adstb});
        @(negedge CLK);
        checkAddr(addr, addrOut);
        checkBusControl(2'b10, {aen, adstb});
        checkDack(4'b0001 << ch, dack);
        checkStrobes(strobes, {memrN, memwN, iorN, iowN});
        @(negedge CLK);
        checkAddr(addr, addrOut);
        checkBusControl(2'b10, {aen, adstb});
        checkEop(!terminal, eopN);
        refAddr[ch] = refAddr[ch] + 16'd1;
        refCount[ch] = refCount[ch] - 16'd1;
        if (terminal)
          refMask[ch] = 1'b1;
        transfers++;
      end
    end
  end

  initial
  begin : watchdog
    repeat (plannedTransfers * cyclesPerTransfer)
      @(posedge CLK);
    abortRun("Watchdog expired before all tests finished");
  end

  initial
  begin : stimulus
    rstN = 1'b0;
    cpuWr = 1'b0;
    cpuSel = '0;
    cpuData = '0;
    dreq = '0;
    refMask = '1;
    refHighByte = 1'b0;
    repeat (3)
      @(posedge CLK);
    #1 rstN = 1'b1;

    testName = "write";
    programChannel(2'd1, 16'h0100, 16'd2, dmaRegPkg::xferWrite);
    unmaskChannel(2'd1);
    repeat (3)
      serveChannel(2'd1);

    // Count ran out on the third transfer
    testName = "terminal";
    raiseReq(4'b0010);
    expectNoRequest(10);
    @(posedge CLK);
    #1 dreq[1] = 1'b0;

    testName = "masking";
    programChannel(2'd2, 16'h2000, 16'd5, dmaRegPkg::xferRead);
    raiseReq(4'b0100);
    expectNoRequest(8);
    unmaskChannel(2'd2);
    finishReq(2'd2);

    testName = "verify";
    programChannel(2'd3, 16'h3000, 16'd5, 2'b00);
    unmaskChannel(2'd3);
    serveChannel(2'd3);

    testName = "priority";
    programChannel(2'd0, 16'h0A00, 16'd10, dmaRegPkg::xferWrite);
    unmaskChannel(2'd0);
    raiseReq(4'b1001);
    finishReq(2'd0);
    finishReq(2'd3);

    testName = "guard";
    raiseReq(4'b0001);
    @(negedge CLK);
    while (!hlda)
      @(negedge CLK);
    writeReg(4'd0, 8'hEE);
    finishReq(2'd0);
    serveChannel(2'd0);
    // Leave the flip-flop on the high byte before clearing it
    writeReg(4'd0, 8'h11);
    writeReg(dmaRegPkg::regClearFlipFlopSel, 8'h00);
    writeReg(4'd0, 8'h40);
    writeReg(4'd0, 8'h12);
    serveChannel(2'd0);

    repeat (2)
      @(posedge CLK);
    if (transfers == plannedTransfers)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
      abortRun($sformatf("Only %0d of %0d transfers were seen", transfers, plannedTransfers));
  end

endmodule

//--- src.f
hw/dmaRegPkg.sv
hw/dmaBusPkg.sv
hw/priorityLogic.sv
hw/dmaRegisters.sv
hw/timingControl.sv
hw/dma.sv
testbench/dma_properties.sv
testbench/dmaTb.sv

//--- Makefile
SIM      := verilator
TOP      := dmaTb
FILELIST := src.f
FLAGS    := --binary --timing --assert -j 0
BUILDDIR := obj_dir

SOURCES  := $(shell cat $(FILELIST))
BIN      := $(BUILDDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILDDIR)
